// File: i2c_master.f
+incdir+hdl
hdl/i2c_bus_pkg.sv
hdl/i2c_txn_pkg.sv
hdl/i2c_bit_if.sv
hdl/i2c_tick_gen.sv
hdl/i2c_bit_engine.sv
hdl/i2c_txn_ctrl.sv
hdl/i2c_master.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_master.sv

// File: Bender.yml
package:
  name: i2c_master

export_include_dirs:
  - hdl

sources:
  - hdl/i2c_bus_pkg.sv
  - hdl/i2c_txn_pkg.sv
  - hdl/i2c_bit_if.sv
  - hdl/i2c_tick_gen.sv
  - hdl/i2c_bit_engine.sv
  - hdl/i2c_txn_ctrl.sv
  - hdl/i2c_master.sv
  - target: test
    files:
      - testbench/i2c_slave_model.sv
      - testbench/tb_i2c_master.sv

// File: testbench/tb_i2c_master.sv
`timescale 1ns/10ps

module tb_i2c_master;

    localparam int         BUSY_TIMEOUT = 40000;
    localparam logic [6:0] SLAVE_ADDR   = 7'h50;

    logic        i_clk;
    logic        i_rst;
    logic        i_enable;
    logic        i_rw;
    logic [7:0]  i_mosi_data;
    logic [7:0]  i_reg_addr;
    logic [6:0]  i_device_addr;
    logic [15:0] i_divider;
    logic [7:0]  o_miso_data;
    logic        o_busy;
    logic        o_ack_error;
    logic [7:0]  stretch;
    wire         io_sda;
    wire         io_scl;

    int errors;
    int checks;
    int tests;
    int seed;

    pullup (io_sda);
    pullup (io_scl);

    i2c_master dut_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_enable      (i_enable),
        .i_rw          (i_rw),
        .i_mosi_data   (i_mosi_data),
        .i_reg_addr    (i_reg_addr),
        .i_device_addr (i_device_addr),
        .i_divider     (i_divider),
        .o_miso_data   (o_miso_data),
        .o_busy        (o_busy),
        .o_ack_error   (o_ack_error),
        .io_sda        (io_sda),
        .io_scl        (io_scl)
    );

    i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) slave_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_stretch (stretch),
        .io_sda    (io_sda),
        .io_scl    (io_scl)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s %s expected 0x%0h, got 0x%0h", test, what, expected, actual);
        end
    endtask

    // One transaction and its o_busy pulse
    task automatic run_txn(input string test, input logic rw, input logic [6:0] dev,
                           input logic [7:0] reg_addr, input logic [7:0] data);
        int cycles;
        @(posedge i_clk);
        i_enable      <= 1'b1;
        i_rw          <= rw;
        i_device_addr <= dev;
        i_reg_addr    <= reg_addr;
        i_mosi_data   <= data;
        @(posedge i_clk);
        i_enable <= 1'b0;
        cycles = 0;
        while (!o_busy && cycles < 4) begin
            @(posedge i_clk);
            cycles++;
        end
        if (!o_busy) begin
            errors++;
            $display("%s: o_busy did not rise after i_enable", test);
        end
        cycles = 0;
        while (o_busy && cycles < BUSY_TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (o_busy) begin
            errors++;
            $display("%s: timeout, o_busy still high after %0d cycles", test, BUSY_TIMEOUT);
        end
    endtask

    task automatic end_test(input string test, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", test);
        end else begin
            $display("%s: failed with %0d errors", test, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic idle_after_reset();
        int errors_before;
        errors_before = errors;
        check_value("idle_after_reset", "o_busy", 0, o_busy);
        check_value("idle_after_reset", "o_ack_error", 0, o_ack_error);
        check_value("idle_after_reset", "io_sda", 1, io_sda);
        check_value("idle_after_reset", "io_scl", 1, io_scl);
        end_test("idle_after_reset", errors_before);
    endtask

    task automatic write_then_read(input string test, input logic [7:0] addr,
                                   input logic [7:0] data);
        int errors_before;
        errors_before = errors;
        run_txn(test, 1'b0, SLAVE_ADDR, addr, data);
        check_value(test, "o_ack_error after write", 0, o_ack_error);
        run_txn(test, 1'b1, SLAVE_ADDR, addr, 8'h00);
        check_value(test, "o_ack_error after read", 0, o_ack_error);
        check_value(test, "o_miso_data", data, o_miso_data);
        end_test(test, errors_before);
    endtask

    task automatic read_preloaded();
        int errors_before;
        errors_before = errors;
        slave_i.regs[8'h40] = 8'h3C;
        run_txn("read_preloaded", 1'b1, SLAVE_ADDR, 8'h40, 8'h00);
        check_value("read_preloaded", "o_miso_data", 8'h3C, o_miso_data);
        check_value("read_preloaded", "o_ack_error", 0, o_ack_error);
        end_test("read_preloaded", errors_before);
    endtask

    task automatic absent_device();
        int errors_before;
        errors_before = errors;
        run_txn("absent_device", 1'b0, 7'h33, 8'h05, 8'h77);
        check_value("absent_device", "o_ack_error", 1, o_ack_error);
        check_value("absent_device", "o_busy", 0, o_busy);
        check_value("absent_device", "io_sda", 1, io_sda);
        check_value("absent_device", "io_scl", 1, io_scl);
        end_test("absent_device", errors_before);
    endtask

    task automatic random_write_reads();
        int         errors_before;
        logic [7:0] addr;
        logic [7:0] data;
        errors_before = errors;
        seed = 78;
        for (int i = 0; i < 8; i++) begin
            addr = 8'($random(seed));
            data = 8'($random(seed));
            run_txn("random_write_reads", 1'b0, SLAVE_ADDR, addr, data);
            run_txn("random_write_reads", 1'b1, SLAVE_ADDR, addr, 8'h00);
            check_value("random_write_reads", "o_miso_data", data, o_miso_data);
        end
        end_test("random_write_reads", errors_before);
    endtask

    initial begin
        i_rst         = 1'b1;
        i_enable      = 1'b0;
        i_rw          = 1'b0;
        i_mosi_data   = '0;
        i_reg_addr    = '0;
        i_device_addr = '0;
        i_divider     = 16'd4;
        stretch       = '0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        seed          = 78;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);
        idle_after_reset();
        write_then_read("write_then_read", 8'h12, 8'hA5);
        read_preloaded();
        absent_device();
        @(posedge i_clk);
        stretch <= 8'd20;
        write_then_read("stretched_write_read", 8'h21, 8'h5C);
        @(posedge i_clk);
        stretch <= 8'd0;
        random_write_reads();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/i2c_slave_model.sv
`timescale 1ns/10ps

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic [7:0] i_stretch,
    inout  wire        io_sda,
    inout  wire        io_scl
);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_ADDR  = 3'd1;
    localparam logic [2:0] ST_REG   = 3'd2;
    localparam logic [2:0] ST_WDATA = 3'd3;
    localparam logic [2:0] ST_RDATA = 3'd4;

    logic [7:0] regs [0:255];
    logic [2:0] state;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic [7:0] ptr;
    logic [7:0] tx;
    logic [7:0] stretch_cnt;
    logic       sda_low;
    logic       scl_low;
    logic       scl_q;
    logic       sda_q;
    logic       scl_in;
    logic       sda_in;

    assign io_sda = sda_low ? 1'b0 : 1'bz;
    assign io_scl = scl_low ? 1'b0 : 1'bz;
    assign scl_in = (io_scl !== 1'b0);
    assign sda_in = (io_sda !== 1'b0);

    initial begin
        for (int i = 0; i < 256; i++) begin
            regs[i] = 8'(i) ^ 8'h96;
        end
    end

    // Bus sampled on the system clock, edges found against the previous sample
    always @(posedge i_clk) begin
        scl_q <= scl_in;
        sda_q <= sda_in;
        if (stretch_cnt != 8'd0) begin
            stretch_cnt <= stretch_cnt - 8'd1;
            if (stretch_cnt == 8'd1) begin
                scl_low <= 1'b0;
            end
        end
        if (i_rst) begin
            state       <= ST_IDLE;
            bit_cnt     <= '0;
            ptr         <= '0;
            stretch_cnt <= '0;
            sda_low     <= 1'b0;
            scl_low     <= 1'b0;
        end else if (scl_in && scl_q && sda_q && !sda_in) begin
            // START or repeated START
            state   <= ST_ADDR;
            bit_cnt <= '0;
            sda_low <= 1'b0;
        end else if (scl_in && scl_q && !sda_q && sda_in) begin
            state   <= ST_IDLE;
            sda_low <= 1'b0;
        end else if (state != ST_IDLE && scl_in && !scl_q) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (state != ST_RDATA && bit_cnt < 4'd8) begin
                shreg <= {shreg[6:0], sda_in};
            end
        end else if (state != ST_IDLE && !scl_in && scl_q) begin
            if (i_stretch != 8'd0) begin
                scl_low     <= 1'b1;
                stretch_cnt <= i_stretch;
            end
            if (state == ST_RDATA) begin
                if (bit_cnt < 4'd8) begin
                    sda_low <= !tx[3'd7 - bit_cnt[2:0]];
                end else if (bit_cnt == 4'd8) begin
                    sda_low <= 1'b0;
                end else begin
                    state <= ST_IDLE;
                end
            end else if (bit_cnt == 4'd8) begin
                // No ACK for a foreign address
                if (state == ST_ADDR && shreg[7:1] != DEV_ADDR) begin
                    state <= ST_IDLE;
                end else begin
                    sda_low <= 1'b1;
                end
            end else if (bit_cnt == 4'd9) begin
                sda_low <= 1'b0;
                bit_cnt <= '0;
                case (state)
                    ST_ADDR: begin
                        if (shreg[0]) begin
                            state   <= ST_RDATA;
                            tx      <= regs[ptr];
                            sda_low <= !regs[ptr][7];
                        end else begin
                            state <= ST_REG;
                        end
                    end
                    ST_REG: begin
                        ptr   <= shreg;
                        state <= ST_WDATA;
                    end
                    default: begin
                        regs[ptr] <= shreg;
                        ptr       <= ptr + 8'd1;
                    end
                endcase
            end
        end
    end

endmodule

// File: hdl/i2c_master.sv
`timescale 1ns/10ps
`include "i2c_master_settings.svh"

module i2c_master (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_enable,
    input  logic                       i_rw,
    input  i2c_txn_pkg::i2c_byte_t     i_mosi_data,
    input  i2c_txn_pkg::i2c_byte_t     i_reg_addr,
    input  logic [`I2C_ADDR_WIDTH-1:0] i_device_addr,
    input  logic [`I2C_DIV_WIDTH-1:0]  i_divider,
    output i2c_txn_pkg::i2c_byte_t     o_miso_data,
    output logic                       o_busy,
    output logic                       o_ack_error,
    inout  wire                        io_sda,
    inout  wire                        io_scl
);

    logic tick;
    logic scl_low;
    logic sda_low;

    i2c_bit_if bit_if_i ();

    i2c_tick_gen tick_gen_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_divider (i_divider),
        .o_tick    (tick)
    );

    i2c_bit_engine bit_engine_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_tick    (tick),
        .i_scl     (io_scl),
        .i_sda     (io_sda),
        .o_scl_low (scl_low),
        .o_sda_low (sda_low),
        .bit_if    (bit_if_i.engine)
    );

    i2c_txn_ctrl txn_ctrl_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_enable      (i_enable),
        .i_rw          (i_rw),
        .i_mosi_data   (i_mosi_data),
        .i_reg_addr    (i_reg_addr),
        .i_device_addr (i_device_addr),
        .o_miso_data   (o_miso_data),
        .o_busy        (o_busy),
        .o_ack_error   (o_ack_error),
        .bit_if        (bit_if_i.ctrl)
    );

    // Open drain, pull-ups give the high level
    assign io_scl = scl_low ? 1'b0 : 1'bz;
    assign io_sda = sda_low ? 1'b0 : 1'bz;

endmodule

// File: hdl/i2c_txn_ctrl.sv
`timescale 1ns/10ps
`include "i2c_master_settings.svh"

module i2c_txn_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_enable,
    input  logic                       i_rw,
    input  i2c_txn_pkg::i2c_byte_t     i_mosi_data,
    input  i2c_txn_pkg::i2c_byte_t     i_reg_addr,
    input  logic [`I2C_ADDR_WIDTH-1:0] i_device_addr,
    output i2c_txn_pkg::i2c_byte_t     o_miso_data,
    output logic                       o_busy,
    output logic                       o_ack_error,
    i2c_bit_if.ctrl                    bit_if
);
    import i2c_bus_pkg::*;
    import i2c_txn_pkg::*;

    localparam logic [3:0] LAST_BIT = 4'(`I2C_BYTE_WIDTH - 1);
    localparam logic [3:0] ACK_BIT  = 4'(`I2C_BYTE_WIDTH);

    i2c_txn_state_e             state;
    logic [3:0]                 bit_cnt;
    i2c_byte_t                  sh;
    logic [`I2C_ADDR_WIDTH-1:0] dev_q;
    i2c_byte_t                  reg_q;
    i2c_byte_t                  data_q;
    logic                       rw_q;
    i2c_cmd_e                   cmd_q;
    logic                       cmd_valid_q;
    logic                       tx_q;

    always_ff @(posedge i_clk) begin
        cmd_valid_q <= 1'b0;
        if (state == TXN_IDLE) begin
            if (i_enable) begin
                dev_q       <= i_device_addr;
                reg_q       <= i_reg_addr;
                data_q      <= i_mosi_data;
                rw_q        <= i_rw;
                o_busy      <= 1'b1;
                o_ack_error <= 1'b0;
                state       <= TXN_START;
                cmd_q       <= CMD_START;
                cmd_valid_q <= 1'b1;
            end
        end else if (bit_if.done) begin
            // Every finished operation except STOP is followed by another
            cmd_valid_q <= 1'b1;
            bit_cnt     <= '0;
            case (state)
                TXN_START, TXN_RESTART: begin
                    state <= (state == TXN_START) ? TXN_DEV_W : TXN_DEV_R;
                    sh    <= {dev_q, state == TXN_RESTART};
                    cmd_q <= CMD_BIT;
                    tx_q  <= dev_q[`I2C_ADDR_WIDTH-1];
                end
                TXN_STOP: begin
                    state       <= TXN_IDLE;
                    o_busy      <= 1'b0;
                    cmd_valid_q <= 1'b0;
                end
                default: begin
                    if (bit_cnt != ACK_BIT) begin
                        // MSB first; received bits shift in at the bottom
                        sh      <= {sh[`I2C_BYTE_WIDTH-2:0], bit_if.rx_bit};
                        bit_cnt <= bit_cnt + 4'd1;
                        if (state == TXN_DATA_R || bit_cnt == LAST_BIT) begin
                            tx_q <= 1'b1;
                        end else begin
                            tx_q <= sh[`I2C_BYTE_WIDTH-2];
                        end
                    end else if (state != TXN_DATA_R && bit_if.rx_bit) begin
                        // Missing ACK, abort
                        o_ack_error <= 1'b1;
                        state       <= TXN_STOP;
                        cmd_q       <= CMD_STOP;
                    end else begin
                        case (state)
                            TXN_DEV_W: begin
                                state <= TXN_REG;
                                sh    <= reg_q;
                                tx_q  <= reg_q[`I2C_BYTE_WIDTH-1];
                            end
                            TXN_REG: begin
                                if (rw_q) begin
                                    state <= TXN_RESTART;
                                    cmd_q <= CMD_START;
                                end else begin
                                    state <= TXN_DATA_W;
                                    sh    <= data_q;
                                    tx_q  <= data_q[`I2C_BYTE_WIDTH-1];
                                end
                            end
                            TXN_DEV_R: begin
                                // Slave drives the data, master keeps SDA released
                                state <= TXN_DATA_R;
                                tx_q  <= 1'b1;
                            end
                            default: begin
                                state <= TXN_STOP;
                                cmd_q <= CMD_STOP;
                                if (state == TXN_DATA_R) begin
                                    o_miso_data <= sh;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
        if (i_rst) begin
            state       <= TXN_IDLE;
            bit_cnt     <= '0;
            cmd_q       <= CMD_STOP;
            cmd_valid_q <= 1'b0;
            o_busy      <= 1'b0;
            o_ack_error <= 1'b0;
        end
    end

    assign bit_if.cmd       = cmd_q;
    assign bit_if.cmd_valid = cmd_valid_q;
    assign bit_if.tx_bit    = tx_q;

endmodule

// File: hdl/i2c_bit_engine.sv
`timescale 1ns/10ps

module i2c_bit_engine (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_tick,
    input  logic      i_scl,
    input  logic      i_sda,
    output logic      o_scl_low,
    output logic      o_sda_low,
    i2c_bit_if.engine bit_if
);
    import i2c_bus_pkg::*;

    i2c_cmd_e   cmd_q;
    i2c_phase_t phase;
    logic       active;
    logic       done_q;
    logic       rx_q;
    logic [1:0] scl_sync;
    logic [1:0] sda_sync;
    logic       scl_wait;
    logic       step;

    // Bus lines are asynchronous to i_clk
    always_ff @(posedge i_clk) begin
        scl_sync <= {scl_sync[0], i_scl};
        sda_sync <= {sda_sync[0], i_sda};
    end

    // Phases that hold until SCL is really high (stretching)
    assign scl_wait = (cmd_q == CMD_BIT) ? (phase == 2'd1) : (phase == 2'd2);
    assign step     = active && i_tick && (!scl_wait || scl_sync[1]);

    ////////////////////////////////////////
    // Phase sequencer
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        done_q <= 1'b0;
        if (!active && bit_if.cmd_valid) begin
            active <= 1'b1;
            cmd_q  <= bit_if.cmd;
            phase  <= '0;
            // Data set up while SCL is still low
            if (bit_if.cmd == CMD_BIT) begin
                o_sda_low <= ~bit_if.tx_bit;
            end
        end else if (step) begin
            phase <= phase + 2'd1;
            case (cmd_q)
                CMD_START: begin
                    // SDA released first, so this also serves as repeated START
                    case (phase)
                        2'd0: o_sda_low <= 1'b0;
                        2'd1: o_scl_low <= 1'b0;
                        2'd2: o_sda_low <= 1'b1;
                        default: o_scl_low <= 1'b1;
                    endcase
                end
                CMD_STOP: begin
                    case (phase)
                        2'd0: o_sda_low <= 1'b1;
                        2'd1: o_scl_low <= 1'b0;
                        2'd3: o_sda_low <= 1'b0;
                        default: ;
                    endcase
                end
                default: begin
                    if (phase == 2'd0) begin
                        o_scl_low <= 1'b0;
                    end
                    if (phase == 2'd2) begin
                        rx_q      <= sda_sync[1];
                        o_scl_low <= 1'b1;
                    end
                end
            endcase
            if (phase == 2'd3) begin
                active <= 1'b0;
                done_q <= 1'b1;
            end
        end
        if (i_rst) begin
            active    <= 1'b0;
            done_q    <= 1'b0;
            phase     <= '0;
            cmd_q     <= CMD_STOP;
            o_scl_low <= 1'b0;
            o_sda_low <= 1'b0;
        end
    end

    assign bit_if.rx_bit = rx_q;
    assign bit_if.done   = done_q;

endmodule

// File: hdl/i2c_tick_gen.sv
`timescale 1ns/10ps
`include "i2c_master_settings.svh"

module i2c_tick_gen (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic [`I2C_DIV_WIDTH-1:0] i_divider,
    output logic                      o_tick
);

    logic [`I2C_DIV_WIDTH-1:0] count;

    // Wraps at i_divider, one tick per i_divider+1 clocks
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (count >= i_divider) begin
            count  <= '0;
            o_tick <= 1'b1;
        end else begin
            count  <= count + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

// File: hdl/i2c_bit_if.sv
`timescale 1ns/10ps

interface i2c_bit_if;
    import i2c_bus_pkg::*;

    i2c_cmd_e cmd;
    logic     cmd_valid;
    // 1 releases SDA, 0 pulls it low
    logic     tx_bit;
    logic     rx_bit;
    logic     done;

    modport ctrl (
        output cmd, cmd_valid, tx_bit,
        input  rx_bit, done
    );

    modport engine (
        input  cmd, cmd_valid, tx_bit,
        output rx_bit, done
    );
endinterface

// File: hdl/i2c_txn_pkg.sv
`include "i2c_master_settings.svh"

package i2c_txn_pkg;

    typedef logic [`I2C_BYTE_WIDTH-1:0] i2c_byte_t;

    // Steps of a single-register write or read
    typedef enum logic [3:0] {
        TXN_IDLE    = 4'd0,
        TXN_START   = 4'd1,
        TXN_DEV_W   = 4'd2,
        TXN_REG     = 4'd3,
        TXN_DATA_W  = 4'd4,
        TXN_RESTART = 4'd5,
        TXN_DEV_R   = 4'd6,
        TXN_DATA_R  = 4'd7,
        TXN_STOP    = 4'd8
    } i2c_txn_state_e;

endpackage

// File: hdl/i2c_bus_pkg.sv
package i2c_bus_pkg;

    // Operations the bit engine performs on the lines
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_BIT   = 2'd2
    } i2c_cmd_e;

    // Quarter-bit phase within one operation
    typedef logic [1:0] i2c_phase_t;

endpackage

// File: hdl/i2c_master_settings.svh
`ifndef I2C_MASTER_SETTINGS_SVH
`define I2C_MASTER_SETTINGS_SVH

// 7-bit device address
`define I2C_ADDR_WIDTH 7

// Register address and data byte
`define I2C_BYTE_WIDTH 8

// Bus-phase divider input
`define I2C_DIV_WIDTH 16

`endif
